/* tb.f */
+incdir+include
design/jc_pkg.sv
design/update_arbiter.sv
design/branch_predictor.sv
design/jalr_predictor.sv
design/jump_controller.sv
tb/jump_controller_checker.sv
tb/tb_jump_controller.sv

/* Bender.yml */
package:
  name: jump_controller

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/jc_pkg.sv
      - design/update_arbiter.sv
      - design/branch_predictor.sv
      - design/jalr_predictor.sv
      - design/jump_controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/jump_controller_checker.sv
      - tb/tb_jump_controller.sv

/* tb/tb_jump_controller.sv */
`timescale 1ns/1ps
`include "jc_params.svh"

module tb_jump_controller;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int LEN_RESET    = 8;
	localparam int LEN_DECODE   = 200;
	localparam int LEN_TRAIN    = 13;
	localparam int LEN_ARB      = 15;
	localparam int LEN_JALR     = 10;
	localparam int LEN_MIXED    = 300;
	localparam int BUDGET       = RESET_CYCLES + LEN_RESET + LEN_DECODE + LEN_TRAIN
		+ LEN_ARB + LEN_JALR + LEN_MIXED + 100;

	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_ALU    = 7'b0010011; // Never redirects

	logic                                  clk;
	logic                                  arst_n;
	logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]    pc;
	logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]    instr;
	logic [`JC_FU_PORTS-1:0]               br_upd_valid;
	logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0] br_upd_pc;
	logic [`JC_FU_PORTS-1:0]               jalr_upd_valid;
	logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0] jalr_upd_pc;
	logic [`JC_FU_PORTS-1:0]               mispredict;
	logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0] correct_pc;
	logic [`JC_SLOTS-1:0]                  jump;
	logic [`JC_SLOTS-1:0]                  jalr;
	logic                                  jalr_pred_valid;
	logic [`JC_XLEN-1:0]                   jalr_pred_target;

	// Reference copy of both tables and the arbiter pointer
	logic [1:0]  ref_bht  [`JC_BHT_ENTRIES];
	logic        ref_jv   [`JC_JTB_ENTRIES];
	logic [25:0] ref_jtag [`JC_JTB_ENTRIES];
	logic [31:0] ref_jtgt [`JC_JTB_ENTRIES];
	int          ref_ptr;

	logic [31:0] lcg_state = 32'h6a49_480e;
	int          test_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	jump_controller UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * BUDGET);
		$display("Watchdog expired before all tests completed");
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] make_instr(input logic [6:0] op);
		logic [31:0] r;
		r = next_rand();
		return {r[31:7], op};
	endfunction

	// Narrow PC region so tags repeat and the JALR table hits
	function automatic logic [31:0] region_pc();
		return 32'h0000_4000 | (next_rand() & 32'h0000_01FC);
	endfunction

	task automatic fill_plain_group();
		for (int s = 0; s < `JC_SLOTS; s++) begin
			pc[s]    = next_rand();
			instr[s] = make_instr(OP_ALU);
		end
	endtask

	task automatic clear_reports();
		br_upd_valid   = '0;
		jalr_upd_valid = '0;
		mispredict     = '0;
	endtask

	task automatic report_mismatch(input string name, input string sig,
		input logic [31:0] exp, input logic [31:0] act);
		$display("FAIL %s %s expected %h actual %h", name, sig, exp, act);
		test_errors++;
	endtask

	task automatic check_outputs(input string name);
		logic [`JC_SLOTS-1:0] exp_jump;
		logic [`JC_SLOTS-1:0] exp_jalr;
		logic                 exp_pv;
		logic [31:0]          exp_pt;
		logic [6:0]           op;
		exp_jump = '0;
		exp_jalr = '0;
		exp_pv   = 1'b0;
		exp_pt   = '0;
		for (int s = 0; s < `JC_SLOTS; s++) begin
			op = instr[s][6:0];
			if (op == OP_JAL || (op == OP_BRANCH && ref_bht[pc[s][6:2]][1])) begin
				exp_jump[s] = 1'b1;
			end
			if (op == OP_JALR) begin
				exp_jalr[s] = 1'b1;
				// First hitting slot supplies the target
				if (!exp_pv && ref_jv[pc[s][5:2]] && ref_jtag[pc[s][5:2]] == pc[s][31:6]) begin
					exp_pv = 1'b1;
					exp_pt = ref_jtgt[pc[s][5:2]];
				end
			end
		end
		assert (jump === exp_jump) else report_mismatch(name, "jump", exp_jump, jump);
		assert (jalr === exp_jalr) else report_mismatch(name, "jalr", exp_jalr, jalr);
		assert (jalr_pred_valid === exp_pv)
			else report_mismatch(name, "jalr_pred_valid", exp_pv, jalr_pred_valid);
		if (exp_pv) begin
			assert (jalr_pred_target === exp_pt)
				else report_mismatch(name, "jalr_pred_target", exp_pt, jalr_pred_target);
		end
	endtask

	// Applies this cycle's winning report to the reference tables
	task automatic ref_update();
		logic [2:0]  req;
		logic [1:0]  c;
		logic [31:0] upc;
		logic        go_taken;
		int          win;
		int          p;
		req = br_upd_valid | jalr_upd_valid;
		win = -1;
		for (int k = 0; k < `JC_FU_PORTS; k++) begin
			p = (ref_ptr + k) % `JC_FU_PORTS;
			if (win < 0 && req[p]) begin
				win = p;
			end
		end
		if (win >= 0) begin
			if (br_upd_valid[win]) begin
				upc      = br_upd_pc[win];
				c        = ref_bht[upc[6:2]];
				go_taken = mispredict[win] ? !c[1] : c[1];
				if (go_taken && c != 2'd3) begin
					c = c + 2'd1;
				end else if (!go_taken && c != 2'd0) begin
					c = c - 2'd1;
				end
				ref_bht[upc[6:2]] = c;
			end else begin
				upc                = jalr_upd_pc[win];
				ref_jv[upc[5:2]]   = 1'b1;
				ref_jtag[upc[5:2]] = upc[31:6];
				ref_jtgt[upc[5:2]] = correct_pc[win];
			end
			ref_ptr = (win + 1) % `JC_FU_PORTS;
		end
	endtask

	// Entered and left on a falling edge
	task automatic run_cycle(input string name);
		#(CLK_PERIOD / 4); // Settled, rising edge still ahead
		check_outputs(name);
		@(posedge clk);
		ref_update();
		@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("PASS %s", name);
			tests_passed++;
		end else begin
			$display("FAIL %s with %0d mismatched checks", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	initial begin
		logic [31:0] r;
		logic [6:0]  op;
		logic [11:0] train_mp;
		logic [31:0] jpc;
		logic [31:0] kpc;
		arst_n      = 1'b0;
		pc          = '0;
		instr       = '0;
		br_upd_pc   = '0;
		jalr_upd_pc = '0;
		correct_pc  = '0;
		clear_reports();
		for (int e = 0; e < `JC_BHT_ENTRIES; e++) begin
			ref_bht[e] = 2'd1; // Weakly not taken
		end
		for (int e = 0; e < `JC_JTB_ENTRIES; e++) begin
			ref_jv[e] = 1'b0;
		end
		ref_ptr = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		////////////////////////////////////////
		// Reset state and decode
		////////////////////////////////////////
		for (int n = 0; n < LEN_RESET; n++) begin
			for (int s = 0; s < `JC_SLOTS; s++) begin
				pc[s]    = next_rand();
				instr[s] = make_instr((s % 2 == 0) ? OP_BRANCH : OP_JALR);
			end
			run_cycle("reset_state");
		end
		finish_test("reset_state");

		for (int n = 0; n < LEN_DECODE; n++) begin
			for (int s = 0; s < `JC_SLOTS; s++) begin
				r        = next_rand();
				op       = (r[1:0] == 2'd0) ? OP_JAL : (r[1:0] == 2'd1) ? OP_JALR :
					(r[1:0] == 2'd2) ? OP_BRANCH : r[8:2];
				pc[s]    = next_rand();
				instr[s] = make_instr(op);
			end
			run_cycle("decode");
		end
		finish_test("decode");

		////////////////////////////////////////
		// Counter training on one PC
		////////////////////////////////////////
		train_mp = 12'hC63; // Two wrong, three right, repeated
		for (int n = 0; n < LEN_TRAIN; n++) begin
			fill_plain_group();
			pc[0]    = 32'h0000_2040;
			pc[2]    = 32'h0000_2040;
			instr[0] = make_instr(OP_BRANCH);
			instr[2] = make_instr(OP_BRANCH);
			clear_reports();
			if (n < 12) begin
				br_upd_valid[0] = 1'b1;
				br_upd_pc[0]    = 32'h0000_2040;
				mispredict[0]   = train_mp[n];
			end
			run_cycle("counter_training");
		end
		finish_test("counter_training");

		////////////////////////////////////////
		// Arbitration under full contention
		////////////////////////////////////////
		for (int n = 0; n < LEN_ARB; n++) begin
			fill_plain_group();
			clear_reports();
			for (int p = 0; p < `JC_FU_PORTS; p++) begin
				pc[p]          = 32'h0000_1000 + 4 * p;
				instr[p]       = make_instr(OP_BRANCH);
				jalr_upd_pc[p] = 32'h0000_5010 + 4 * p;
				correct_pc[p]  = next_rand();
				if (n < 9 || (n < 12 && p == 0)) begin
					br_upd_valid[p] = 1'b1;
					br_upd_pc[p]    = 32'h0000_1000 + 4 * p;
					mispredict[p]   = 1'b1;
				end
				if (n >= 9 && n < 12) begin
					jalr_upd_valid[p] = 1'b1;
				end
			end
			if (n >= 12) begin
				clear_reports();
				pc[0]    = 32'h0000_5010 + 4 * (n - 12);
				instr[0] = make_instr(OP_JALR);
			end
			run_cycle("arbitration");
		end
		finish_test("arbitration");

		////////////////////////////////////////
		// JALR targets
		////////////////////////////////////////
		jpc = 32'h0001_2348;
		kpc = 32'h0003_0064;
		for (int n = 0; n < LEN_JALR; n++) begin
			fill_plain_group();
			clear_reports();
			case (n)
				0: begin
					jalr_upd_valid[1] = 1'b1;
					jalr_upd_pc[1]    = jpc;
					correct_pc[1]     = next_rand();
				end
				1, 2, 3, 4, 5: begin
					pc[n - 1]    = jpc;
					instr[n - 1] = make_instr(OP_JALR);
				end
				6: begin
					pc[0]    = jpc ^ 32'h0000_0400; // Same index, other tag
					instr[0] = make_instr(OP_JALR);
				end
				7: begin
					jalr_upd_valid[2] = 1'b1;
					jalr_upd_pc[2]    = kpc;
					correct_pc[2]     = next_rand();
				end
				default: begin
					pc[1]    = (n == 8) ? kpc : jpc;
					pc[3]    = (n == 8) ? jpc : kpc;
					instr[1] = make_instr(OP_JALR);
					instr[3] = make_instr(OP_JALR);
				end
			endcase
			run_cycle("jalr_targets");
		end
		finish_test("jalr_targets");

		////////////////////////////////////////
		// Random traffic on both sides
		////////////////////////////////////////
		for (int n = 0; n < LEN_MIXED; n++) begin
			for (int s = 0; s < `JC_SLOTS; s++) begin
				r        = next_rand();
				pc[s]    = region_pc();
				instr[s] = make_instr(r[0] ? OP_JALR : (r[1] ? OP_BRANCH : OP_JAL));
			end
			r              = next_rand();
			br_upd_valid   = r[2:0] & r[11:9];
			jalr_upd_valid = r[5:3];
			mispredict     = r[8:6];
			for (int p = 0; p < `JC_FU_PORTS; p++) begin
				br_upd_pc[p]   = region_pc();
				jalr_upd_pc[p] = region_pc();
				correct_pc[p]  = next_rand();
			end
			run_cycle("mixed_traffic");
		end
		clear_reports();
		finish_test("mixed_traffic");

		$display("Tests passed: %0d, failed: %0d, checker assertion failures: %0d",
			tests_passed, tests_failed, UUT.checker_inst.fail_count);
		if (tests_failed == 0 && UUT.checker_inst.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* tb/jump_controller_checker.sv */
`timescale 1ns/1ps
`include "jc_params.svh"

module jump_controller_checker (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]    instr,
	input  logic [`JC_FU_PORTS-1:0]               br_upd_valid,
	input  logic [`JC_FU_PORTS-1:0]               jalr_upd_valid,
	input  logic [`JC_SLOTS-1:0]                  jump,
	input  logic [`JC_SLOTS-1:0]                  jalr,
	input  logic                                  jalr_pred_valid,
	input  logic                                  upd_valid,
	input  jc_pkg::upd_kind_e                     upd_kind
);

	int unsigned fail_count = 0;

	////////////////////////////////////////
	// Update bus
	////////////////////////////////////////

	a_upd_valid_on_request: assert property (@(posedge clk) disable iff (!arst_n)
		upd_valid == |(br_upd_valid | jalr_upd_valid))
		else begin
			$error("Update bus valid does not match the port requests");
			fail_count++;
		end

	// Kind must come from a port that actually reports that kind
	a_kind_has_source: assert property (@(posedge clk) disable iff (!arst_n)
		upd_valid |-> (upd_kind == jc_pkg::UPD_BRANCH ? |br_upd_valid : |jalr_upd_valid))
		else begin
			$error("Update kind names a table no port is reporting for");
			fail_count++;
		end

	////////////////////////////////////////
	// Prediction outputs
	////////////////////////////////////////

	a_pred_needs_jalr: assert property (@(posedge clk) disable iff (!arst_n)
		jalr_pred_valid |-> |jalr)
		else begin
			$error("JALR prediction valid without any JALR slot");
			fail_count++;
		end

	a_empty_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> !jalr_pred_valid)
		else begin
			$error("JALR table hit right after reset");
			fail_count++;
		end

	for (genvar s = 0; s < `JC_SLOTS; s++) begin : g_slot
		a_jal_jumps: assert property (@(posedge clk) disable iff (!arst_n)
			(instr[s][6:0] == jc_pkg::JAL) |-> jump[s])
			else begin
				$error("Slot %0d JAL not flagged as a jump", s);
				fail_count++;
			end

		a_jump_only_cf: assert property (@(posedge clk) disable iff (!arst_n)
			jump[s] |-> (instr[s][6:0] == jc_pkg::JAL || instr[s][6:0] == jc_pkg::BRANCH))
			else begin
				$error("Slot %0d jump flagged for a non-jump opcode", s);
				fail_count++;
			end
	end

endmodule

bind jump_controller jump_controller_checker checker_inst (
	.clk             (clk),
	.arst_n          (arst_n),
	.instr           (instr),
	.br_upd_valid    (br_upd_valid),
	.jalr_upd_valid  (jalr_upd_valid),
	.jump            (jump),
	.jalr            (jalr),
	.jalr_pred_valid (jalr_pred_valid),
	.upd_valid       (upd_valid),
	.upd_kind        (upd_kind)
);

/* design/jump_controller.sv */
`timescale 1ns/1ps
`include "jc_params.svh"

module jump_controller (
	input  logic                                     clk,
	input  logic                                     arst_n,

	// Fetch group
	input  logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]       pc,
	input  logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]       instr,

	// Resolution reports from the functional units
	input  logic [`JC_FU_PORTS-1:0]                  br_upd_valid,
	input  logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0]    br_upd_pc,
	input  logic [`JC_FU_PORTS-1:0]                  jalr_upd_valid,
	input  logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0]    jalr_upd_pc,
	input  logic [`JC_FU_PORTS-1:0]                  mispredict,
	input  logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0]    correct_pc,

	// Per-slot decisions
	output logic [`JC_SLOTS-1:0]                     jump, // 1 : redirect
	output logic [`JC_SLOTS-1:0]                     jalr,

	output logic                                     jalr_pred_valid,
	output logic [`JC_XLEN-1:0]                      jalr_pred_target
);

	logic [`JC_SLOTS-1:0] is_jal;
	logic [`JC_SLOTS-1:0] is_branch;
	logic [`JC_SLOTS-1:0] bht_taken;

	// Shared update bus
	logic                 upd_valid;
	jc_pkg::upd_kind_e    upd_kind;
	logic [`JC_XLEN-1:0]  upd_pc;
	logic                 upd_mispredict;
	logic [`JC_XLEN-1:0]  upd_target;

	////////////////////////////////////////
	// Slot decode
	////////////////////////////////////////

	for (genvar s = 0; s < `JC_SLOTS; s++) begin : g_decode
		assign is_jal[s]    = (instr[s][6:0] == jc_pkg::JAL);
		assign is_branch[s] = (instr[s][6:0] == jc_pkg::BRANCH);
		assign jalr[s]      = (instr[s][6:0] == jc_pkg::JALR);
	end

	// Counter only matters for real B-type slots
	assign jump = is_jal | (is_branch & bht_taken);

	////////////////////////////////////////
	// Update arbitration
	////////////////////////////////////////

	update_arbiter update_arbiter_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.br_upd_valid   (br_upd_valid),
		.jalr_upd_valid (jalr_upd_valid),
		.br_upd_pc      (br_upd_pc),
		.jalr_upd_pc    (jalr_upd_pc),
		.mispredict     (mispredict),
		.correct_pc     (correct_pc),
		.upd_valid      (upd_valid),
		.upd_kind       (upd_kind),
		.upd_pc         (upd_pc),
		.upd_mispredict (upd_mispredict),
		.upd_target     (upd_target)
	);

	////////////////////////////////////////
	// Prediction tables
	////////////////////////////////////////

	branch_predictor branch_predictor_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.pc             (pc),
		.upd_valid      (upd_valid),
		.upd_kind       (upd_kind),
		.upd_pc         (upd_pc),
		.upd_mispredict (upd_mispredict),
		.taken          (bht_taken)
	);

	// One target per group, taken from the first hitting JALR
	jalr_predictor jalr_predictor_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.pc          (pc),
		.is_jalr     (jalr),
		.upd_valid   (upd_valid),
		.upd_kind    (upd_kind),
		.upd_pc      (upd_pc),
		.upd_target  (upd_target),
		.pred_valid  (jalr_pred_valid),
		.pred_target (jalr_pred_target)
	);

endmodule

/* design/jalr_predictor.sv */
`timescale 1ns/1ps
`include "jc_params.svh"

module jalr_predictor (
	input  logic                                  clk,
	input  logic                                  arst_n,

	// Lookup side
	input  logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]    pc,
	input  logic [`JC_SLOTS-1:0]                  is_jalr,

	// Shared update bus
	input  logic                                  upd_valid,
	input  jc_pkg::upd_kind_e                     upd_kind,
	input  logic [`JC_XLEN-1:0]                   upd_pc,
	input  logic [`JC_XLEN-1:0]                   upd_target,

	output logic                                  pred_valid,
	output logic [`JC_XLEN-1:0]                   pred_target
);

	localparam int IDX_W   = $clog2(`JC_JTB_ENTRIES);
	localparam int TAG_LSB = IDX_W + 2;          // Skip word offset and index
	localparam int TAG_W   = `JC_XLEN - TAG_LSB;

	////////////////////////////////////////
	// Target table storage
	////////////////////////////////////////

	logic [`JC_JTB_ENTRIES-1:0] jtb_valid;
	logic [TAG_W-1:0]           jtb_tag    [`JC_JTB_ENTRIES];
	logic [`JC_XLEN-1:0]        jtb_target [`JC_JTB_ENTRIES];

	logic [IDX_W-1:0]           slot_idx   [`JC_SLOTS];
	logic [`JC_SLOTS-1:0]       slot_hit;
	logic [IDX_W-1:0]           wr_idx;
	logic                       jtb_we;

	////////////////////////////////////////
	// Lookups
	////////////////////////////////////////

	for (genvar s = 0; s < `JC_SLOTS; s++) begin : g_lookup
		assign slot_idx[s] = pc[s][TAG_LSB-1:2];

		// Only JALR slots may hit
		assign slot_hit[s] = is_jalr[s]
			& jtb_valid[slot_idx[s]]
			& (jtb_tag[slot_idx[s]] == pc[s][`JC_XLEN-1:TAG_LSB]);
	end

	// Lowest hitting slot wins, so scan from the top down
	always_comb begin
		pred_valid  = 1'b0;
		pred_target = '0;
		for (int s = `JC_SLOTS - 1; s >= 0; s--) begin
			if (slot_hit[s]) begin
				pred_valid  = 1'b1;
				pred_target = jtb_target[slot_idx[s]];
			end
		end
	end

	////////////////////////////////////////
	// Update
	////////////////////////////////////////

	assign jtb_we = upd_valid && (upd_kind == jc_pkg::UPD_JALR);
	assign wr_idx = upd_pc[TAG_LSB-1:2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			jtb_valid <= '0;
		end else if (jtb_we) begin
			jtb_valid[wr_idx] <= 1'b1;
		end
	end

	// Written on every JALR report, mispredicted or not
	always_ff @(posedge clk) begin
		if (jtb_we) begin
			jtb_tag[wr_idx]    <= upd_pc[`JC_XLEN-1:TAG_LSB];
			jtb_target[wr_idx] <= upd_target;
		end
	end

endmodule

/* design/branch_predictor.sv */
`timescale 1ns/1ps
`include "jc_params.svh"

module branch_predictor (
	input  logic                                  clk,
	input  logic                                  arst_n,

	// Lookup side, one PC per slot
	input  logic [`JC_SLOTS-1:0][`JC_XLEN-1:0]    pc,

	// Shared update bus
	input  logic                                  upd_valid,
	input  jc_pkg::upd_kind_e                     upd_kind,
	input  logic [`JC_XLEN-1:0]                   upd_pc,
	input  logic                                  upd_mispredict,

	output logic [`JC_SLOTS-1:0]                  taken
);

	localparam int IDX_W = $clog2(`JC_BHT_ENTRIES);

	logic [1:0]       bht [`JC_BHT_ENTRIES]; // 2-bit saturating counters
	logic [IDX_W-1:0] wr_idx;
	logic [1:0]       cur_ctr;
	logic [1:0]       next_ctr;
	logic             bht_we;
	logic             step_up;

	////////////////////////////////////////
	// Lookups
	////////////////////////////////////////

	// Upper counter bit is the predicted direction
	for (genvar s = 0; s < `JC_SLOTS; s++) begin : g_lookup
		assign taken[s] = bht[pc[s][IDX_W+1:2]][1];
	end

	////////////////////////////////////////
	// Training
	////////////////////////////////////////

	assign bht_we  = upd_valid && (upd_kind == jc_pkg::UPD_BRANCH);
	assign wr_idx  = upd_pc[IDX_W+1:2];
	assign cur_ctr = bht[wr_idx];

	// Mispredict flips the sense of the step
	assign step_up = cur_ctr[1] ^ upd_mispredict;

	always_comb begin
		next_ctr = cur_ctr;
		if (step_up) begin
			if (cur_ctr != 2'd3) begin
				next_ctr = cur_ctr + 2'd1;
			end
		end else begin
			if (cur_ctr != 2'd0) begin
				next_ctr = cur_ctr - 2'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < `JC_BHT_ENTRIES; e++) begin
				bht[e] <= 2'b01; // Weakly not taken
			end
		end else if (bht_we) begin
			bht[wr_idx] <= next_ctr;
		end
	end

endmodule

/* design/update_arbiter.sv */
`timescale 1ns/1ps
`include "jc_params.svh"

module update_arbiter (
	input  logic                                     clk,
	input  logic                                     arst_n,

	// Per-FU resolution reports
	input  logic [`JC_FU_PORTS-1:0]                  br_upd_valid,
	input  logic [`JC_FU_PORTS-1:0]                  jalr_upd_valid,
	input  logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0]    br_upd_pc,
	input  logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0]    jalr_upd_pc,
	input  logic [`JC_FU_PORTS-1:0]                  mispredict,
	input  logic [`JC_FU_PORTS-1:0][`JC_XLEN-1:0]    correct_pc,

	// Shared update bus
	output logic                                     upd_valid,
	output jc_pkg::upd_kind_e                        upd_kind,
	output logic [`JC_XLEN-1:0]                      upd_pc,
	output logic                                     upd_mispredict,
	output logic [`JC_XLEN-1:0]                      upd_target
);

	logic [1:0]                  rr_ptr;    // Highest priority port
	logic [1:0]                  grant_idx;
	logic [`JC_FU_PORTS-1:0]     req;
	logic                        take_branch;

	// Port index reached by stepping forward from base, with wrap
	function automatic logic [1:0] port_after(input logic [1:0] base, input int unsigned step);
		int unsigned sum;
		sum = base + step;
		if (sum >= `JC_FU_PORTS) begin
			sum = sum - `JC_FU_PORTS;
		end
		return sum[1:0];
	endfunction

	assign req = br_upd_valid | jalr_upd_valid;

	////////////////////////////////////////
	// Round-robin scan
	////////////////////////////////////////

	// Scan backwards so the closest requester to the pointer wins
	always_comb begin
		grant_idx = rr_ptr;
		for (int k = `JC_FU_PORTS - 1; k >= 0; k--) begin
			if (req[port_after(rr_ptr, k)]) begin
				grant_idx = port_after(rr_ptr, k);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rr_ptr <= 2'd0;
		end else if (upd_valid) begin
			rr_ptr <= port_after(grant_idx, 1); // Winner drops to lowest priority
		end
	end

	////////////////////////////////////////
	// Bus mux
	////////////////////////////////////////

	assign take_branch    = br_upd_valid[grant_idx]; // Branch report beats JALR on one port

	assign upd_valid      = |req;
	assign upd_kind       = take_branch ? jc_pkg::UPD_BRANCH : jc_pkg::UPD_JALR;
	assign upd_pc         = take_branch ? br_upd_pc[grant_idx] : jalr_upd_pc[grant_idx];
	assign upd_mispredict = mispredict[grant_idx];
	assign upd_target     = correct_pc[grant_idx];

endmodule

/* design/jc_pkg.sv */
package jc_pkg;

	////////////////////////////////////////
	// Opcode field, instr[6:0]
	////////////////////////////////////////

	typedef enum logic [6:0] {
		JAL    = 7'b1101111, // Unconditional, always redirects
		JALR   = 7'b1100111, // Register indirect jump
		BRANCH = 7'b1100011  // B-type conditional branch
	} opcode_e;

	////////////////////////////////////////
	// Update bus transfer kind
	////////////////////////////////////////

	// Selects which prediction table a transfer trains
	typedef enum logic {
		UPD_BRANCH = 1'b0, // Bimodal counter table
		UPD_JALR   = 1'b1  // JALR target table
	} upd_kind_e;

endpackage

/* include/jc_params.svh */
`ifndef JC_PARAMS_SVH
`define JC_PARAMS_SVH

// Instruction and PC width
`define JC_XLEN 32

// Instructions per fetch group
`define JC_SLOTS 5

// Functional units reporting resolved control flow
`define JC_FU_PORTS 3

// Bimodal counter table, indexed by PC[6:2]
`define JC_BHT_ENTRIES 32

// JALR target table, indexed by PC[5:2], tagged by PC[31:6]
`define JC_JTB_ENTRIES 16

`endif
